// File: efpga_bridge.f
+incdir+.
efpga_bus_pkg.sv
efpga_ctrl_pkg.sv
reg_access_if.sv
cycle_counter.sv
reg_access_fsm.sv
fabric_reg_bank.sv
control_stabilizer.sv
event_edge_detect.sv
efpga_bridge.sv
efpga_bridge_chk.sv
efpga_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run with Verilator, result is read from the log
cd "$(dirname "$0")" || exit 1
log=sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps \
     --top-module efpga_bridge_tb -f efpga_bridge.f \
  && ./obj_dir/Vefpga_bridge_tb +verilator+error+limit+100; } > "$log" 2>&1 \
  || echo "build or simulation returned an error" >> "$log"
cat "$log"
grep -q "TESTS FAILED" "$log" && exit 1
grep -q "TESTS PASSED" "$log" || exit 1
exit 0

// File: efpga_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "efpga_cfg.svh"

module efpga_bridge_tb
   import efpga_bus_pkg::*;
   import efpga_ctrl_pkg::*;
();

   localparam int CLK_PERIOD  = 8;
   localparam int TEST_CYCLES = 3000;  // rough length of all tests
   localparam int GNT_TIMEOUT = 16;

   logic          asic_clk_i;
   logic          rst_n;
   control_word_t control_i, control_word_o;
   logic          enable_apb_i, apb_req_i, apb_we_i;
   logic          apb_gnt_o, apb_rvalid_o;
   addr_t         apb_addr_i;
   data_t         apb_wdata_i, apb_rdata_o;
   be_t           apb_be_i;
   logic          enable_events_i, enable_perf_i, clear_perf_i;
   event_vec_t    events_i, event_o;
   perf_count_t   perf_count_o;

   integer seed;
   int     checks, errors, test_checks, test_errors, assert_fails;
   string  test_name;
   data_t  model_mem [16];  // reference copy of the register bank

   efpga_bridge dut_i (.*);

   always #(CLK_PERIOD / 2) asic_clk_i = ~asic_clk_i;

   function automatic logic [31:0] next_random();
      return $random(seed);
   endfunction

   // returns the word before the access, merges writes by byte
   function automatic data_t bank_model_access(logic we, addr_t addr, data_t wdata, be_t be);
      data_t      old;
      logic [3:0] word;
      word = addr[5:2];
      old  = model_mem[word];
      if (we) begin
         for (int b = 0; b < 4; b++) begin
            if (be[b]) model_mem[word][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return old;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic end_test();
      $display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
               errors - test_errors);
   endtask

   // one host transfer on the enabled port, checked against the model
   task automatic checked_access(input logic we, input addr_t addr, input data_t wdata,
                                 input be_t be);
      data_t exp;
      int    cycles;
      exp    = bank_model_access(we, addr, wdata, be);
      cycles = 0;
      @(negedge asic_clk_i);
      checks++;
      if (apb_gnt_o !== 1'b0) report_mismatch("idle gnt", 32'd0, 32'(apb_gnt_o));
      apb_req_i   = 1'b1;
      apb_we_i    = we;
      apb_addr_i  = addr;
      apb_wdata_i = wdata;
      apb_be_i    = be;
      do begin
         @(negedge asic_clk_i);
         cycles++;
      end while (apb_gnt_o !== 1'b1 && cycles < GNT_TIMEOUT);
      if (apb_gnt_o !== 1'b1) begin
         errors++;
         $display("%s: no grant within %0d cycles of the request", test_name, GNT_TIMEOUT);
      end else begin
         checks += 3;
         if (cycles != `EFPGA_GNT_CYCLES)
            report_mismatch("grant delay", 32'(`EFPGA_GNT_CYCLES), 32'(cycles));
         if (apb_rvalid_o !== 1'b1) report_mismatch("rvalid", 32'd1, 32'(apb_rvalid_o));
         if (apb_rdata_o !== exp) report_mismatch("rdata", exp, apb_rdata_o);
      end
      apb_req_i = 1'b0;  // host lets go once granted
   endtask

   task automatic random_rw();
      logic [31:0] r, w;
      begin_test("random_rw");
      for (int i = 0; i < 200; i++) begin
         r = next_random();
         w = next_random();
         checked_access(r[20], r[19:0], w, r[24:21]);
      end
      end_test();
   endtask

   task automatic grant_timing();
      logic [31:0] r;
      begin_test("grant_timing");
      for (int i = 0; i < 20; i++) begin
         r = next_random();
         checked_access(1'b0, r[19:0], '0, '0);
      end
      @(negedge asic_clk_i);
      checks++;
      if (apb_gnt_o !== 1'b0) report_mismatch("gnt after release", 32'd0, 32'(apb_gnt_o));
      end_test();
   endtask

   task automatic disabled_port();
      logic [31:0] r, w;
      logic [3:0]  word;
      begin_test("disabled_port");
      @(negedge asic_clk_i);
      enable_apb_i = 1'b0;
      for (int i = 0; i < 20; i++) begin
         r = next_random();
         w = next_random();
         @(negedge asic_clk_i);
         apb_req_i   = 1'b1;
         apb_we_i    = 1'b1;  // must not reach the bank
         apb_addr_i  = r[19:0];
         apb_wdata_i = w;
         apb_be_i    = 4'hf;
         #1;
         checks += 3;
         if (apb_gnt_o !== 1'b1) report_mismatch("gnt", 32'd1, 32'(apb_gnt_o));
         if (apb_rvalid_o !== 1'b1) report_mismatch("rvalid", 32'd1, 32'(apb_rvalid_o));
         if (apb_rdata_o !== '0) report_mismatch("rdata", 32'd0, apb_rdata_o);
         @(negedge asic_clk_i);
         apb_req_i = 1'b0;
         #1;
         checks++;
         if (apb_gnt_o !== 1'b0) report_mismatch("gnt after drop", 32'd0, 32'(apb_gnt_o));
      end
      @(negedge asic_clk_i);
      enable_apb_i = 1'b1;
      for (int i = 0; i < 16; i++) begin
         r    = next_random();
         word = 4'(i);
         checked_access(1'b0, {r[19:6], word, 2'b00}, '0, '0);
      end
      end_test();
   endtask

   task automatic control_word_filter();
      logic [31:0]   r;
      control_word_t prev, value, glitch;
      int            hold, glen;
      begin_test("control_word");
      prev = '0;
      for (int n = 0; n < 40; n++) begin
         value  = next_random();
         glitch = next_random();
         r      = next_random();
         hold   = 5 + int'(r[2:0]);
         glen   = int'(r[4:3]) % 3;  // short pulses, never three samples
         for (int g = 0; g < glen; g++) begin
            @(negedge asic_clk_i);
            checks++;
            if (control_word_o !== prev) report_mismatch("glitch", prev, control_word_o);
            control_i = glitch;
         end
         for (int h = 0; h < hold; h++) begin
            @(negedge asic_clk_i);
            checks++;
            if (control_word_o !== prev && control_word_o !== value)
               report_mismatch("transition", value, control_word_o);
            control_i = value;
         end
         @(negedge asic_clk_i);
         checks++;
         if (control_word_o !== value) report_mismatch("settled", value, control_word_o);
         prev = value;
      end
      end_test();
   endtask

   task automatic event_pulses();
      logic [31:0] r;
      event_vec_t  gated, last_gated, exp_pulse;
      logic        en;
      begin_test("events");
      last_gated = '0;
      exp_pulse  = '0;
      for (int i = 0; i < 300; i++) begin
         @(negedge asic_clk_i);
         checks++;
         if (event_o !== exp_pulse) report_mismatch("event_o", 32'(exp_pulse), 32'(event_o));
         r               = next_random();
         en              = (r[18:16] != 3'b000);  // mostly enabled
         events_i        = r[15:0];
         enable_events_i = en;
         gated           = en ? r[15:0] : '0;
         exp_pulse       = gated & ~last_gated;
         last_gated      = gated;
      end
      end_test();
   endtask

   task automatic perf_counter_track();
      logic [31:0] r;
      perf_count_t exp_count;
      begin_test("perf_counter");
      exp_count = '0;  // idle since reset
      for (int i = 0; i < 300; i++) begin
         @(negedge asic_clk_i);
         checks++;
         if (perf_count_o !== exp_count) report_mismatch("count", exp_count, perf_count_o);
         r             = next_random();
         enable_perf_i = (r[1:0] != 2'b00);
         clear_perf_i  = (r[6:4] == 3'b000);
         if (clear_perf_i) exp_count = '0;
         else if (enable_perf_i) exp_count = exp_count + 1;
      end
      end_test();
   endtask

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d ns before the tests finished",
               2 * TEST_CYCLES * CLK_PERIOD);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      seed            = 32'hb574;
      checks          = 0;
      errors          = 0;
      model_mem       = '{default: '0};
      asic_clk_i      = 1'b0;
      rst_n           = 1'b0;
      control_i       = '0;
      enable_apb_i    = 1'b1;
      apb_req_i       = 1'b0;
      apb_we_i        = 1'b0;
      apb_addr_i      = '0;
      apb_wdata_i     = '0;
      apb_be_i        = '0;
      enable_events_i = 1'b0;
      events_i        = '0;
      enable_perf_i   = 1'b0;
      clear_perf_i    = 1'b0;
      repeat (5) @(posedge asic_clk_i);
      @(negedge asic_clk_i);
      rst_n = 1'b1;
      random_rw();
      grant_timing();
      disabled_port();
      control_word_filter();
      event_pulses();
      perf_counter_track();
      assert_fails = dut_i.chk_i.req_hold_fails + dut_i.chk_i.gnt_repeat_fails
                     + dut_i.chk_i.gnt_rvalid_fails;
      $display("summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: efpga_bridge_chk.sv
`timescale 1ns/1ps
`default_nettype none

module efpga_bridge_chk (
   input logic asic_clk_i,
   input logic rst_n,
   input logic enable_i,
   input logic req_i,
   input logic gnt_i,
   input logic rvalid_i
);

   int req_hold_fails   = 0;
   int gnt_repeat_fails = 0;
   int gnt_rvalid_fails = 0;

   // host keeps req up until the grant cycle
   req_held: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_i && req_i && !gnt_i |=> (req_i || gnt_i))
      else begin
         req_hold_fails = req_hold_fails + 1;
         $error("register request dropped before grant");
      end

   gnt_single: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_i && gnt_i |=> !gnt_i)
      else begin
         gnt_repeat_fails = gnt_repeat_fails + 1;
         $error("grant high on two cycles in a row");
      end

   gnt_with_rvalid: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_i |-> (gnt_i == rvalid_i))
      else begin
         gnt_rvalid_fails = gnt_rvalid_fails + 1;
         $error("grant and read-valid differ on the enabled port");
      end

endmodule

bind efpga_bridge efpga_bridge_chk chk_i (
   .asic_clk_i (asic_clk_i),
   .rst_n      (rst_n),
   .enable_i   (enable_apb_i),
   .req_i      (apb_req_i),
   .gnt_i      (apb_gnt_o),
   .rvalid_i   (apb_rvalid_o)
);

`default_nettype wire

// File: efpga_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "efpga_cfg.svh"

module efpga_bridge
   import efpga_bus_pkg::*;
   import efpga_ctrl_pkg::*;
(
   input  logic          asic_clk_i,
   input  logic          rst_n,
   input  control_word_t control_i,
   output control_word_t control_word_o,
   input  logic          enable_apb_i,
   input  logic          apb_req_i,
   input  logic          apb_we_i,
   input  addr_t         apb_addr_i,
   input  data_t         apb_wdata_i,
   input  be_t           apb_be_i,
   output logic          apb_gnt_o,
   output logic          apb_rvalid_o,
   output data_t         apb_rdata_o,
   input  logic          enable_events_i,
   input  event_vec_t    events_i,
   output event_vec_t    event_o,
   input  logic          enable_perf_i,
   input  logic          clear_perf_i,
   output perf_count_t   perf_count_o
);

   reg_access_if bank_if ();

   reg_access_fsm reg_access_fsm_i (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .enable_i   (enable_apb_i),
      .req_i      (apb_req_i),
      .we_i       (apb_we_i),
      .addr_i     (apb_addr_i),
      .wdata_i    (apb_wdata_i),
      .be_i       (apb_be_i),
      .gnt_o      (apb_gnt_o),
      .rvalid_o   (apb_rvalid_o),
      .rdata_o    (apb_rdata_o),
      .bank       (bank_if.requester)
   );

   // stands in for the fabric register space
   fabric_reg_bank fabric_reg_bank_i (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .port       (bank_if.responder)
   );

   control_stabilizer control_stabilizer_i (
      .asic_clk_i     (asic_clk_i),
      .rst_n          (rst_n),
      .control_i      (control_i),
      .control_word_o (control_word_o)
   );

   event_edge_detect event_edge_detect_i (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .enable_i   (enable_events_i),
      .events_i   (events_i),
      .event_o    (event_o)
   );

   cycle_counter #(.WIDTH(`EFPGA_PERF_W)) perf_counter_i (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .en_i       (enable_perf_i),
      .clr_i      (clear_perf_i),
      .count_o    (perf_count_o)
   );

endmodule

`default_nettype wire

// File: event_edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module event_edge_detect
   import efpga_ctrl_pkg::*;
(
   input  logic       asic_clk_i,
   input  logic       rst_n,
   input  logic       enable_i,
   input  event_vec_t events_i,
   output event_vec_t event_o
);

   event_vec_t gated;
   event_vec_t gated_q;

   assign gated = events_i & {$bits(event_vec_t){enable_i}};

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         gated_q <= '0;
         event_o <= '0;
      end else begin
         gated_q <= gated;
         event_o <= gated & ~gated_q;  // rising bits only
      end
   end

endmodule

`default_nettype wire

// File: control_stabilizer.sv
`timescale 1ns/1ps
`default_nettype none

module control_stabilizer
   import efpga_ctrl_pkg::*;
(
   input  logic          asic_clk_i,
   input  logic          rst_n,
   input  control_word_t control_i,
   output control_word_t control_word_o
);

   control_word_t ctrl_d1, ctrl_d2;
   logic          stable;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_d1        <= '0;
         ctrl_d2        <= '0;
         stable         <= 1'b0;
         control_word_o <= '0;
      end else begin
         ctrl_d1 <= control_i;
         ctrl_d2 <= ctrl_d1;
         // three matching samples in a row
         stable  <= (ctrl_d1 == control_i) && (ctrl_d2 == control_i);
         if (stable) control_word_o <= ctrl_d1;  // d1 holds the checked sample
      end
   end

endmodule

`default_nettype wire

// File: fabric_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "efpga_cfg.svh"

module fabric_reg_bank
   import efpga_bus_pkg::*;
(
   input  logic            asic_clk_i,
   input  logic            rst_n,
   reg_access_if.responder port
);

   data_t    mem_q [`EFPGA_REG_WORDS];
   reg_idx_t idx;

   assign idx = addr_to_idx(port.addr);

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         mem_q       <= '{default: '0};
         port.rvalid <= 1'b0;
      end else begin
         port.rvalid <= port.req;  // every access answered next cycle
         if (port.req && port.we) begin
            for (int b = 0; b < BE_W; b++) begin
               if (port.be[b]) mem_q[idx][8*b +: 8] <= port.wdata[8*b +: 8];
            end
         end
      end
   end

   // read-before-write, also returned on writes
   always_ff @(posedge asic_clk_i) begin
      if (port.req) begin
         port.rdata <= mem_q[idx];
      end
   end

endmodule

`default_nettype wire

// File: reg_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "efpga_cfg.svh"

module reg_access_fsm
   import efpga_bus_pkg::*;
   import efpga_ctrl_pkg::*;
(
   input  logic           asic_clk_i,
   input  logic           rst_n,
   input  logic           enable_i,
   input  logic           req_i,
   input  logic           we_i,
   input  addr_t          addr_i,
   input  data_t          wdata_i,
   input  be_t            be_i,
   output logic           gnt_o,
   output logic           rvalid_o,
   output data_t          rdata_o,
   reg_access_if.requester bank
);

   // timer misses the IDLE sample and the current one
   localparam logic [2:0] HOLD_LAST = 3'(`EFPGA_GNT_CYCLES - 2);

   access_state_t state_q, state_d;
   logic [2:0]    hold_cnt;
   logic          issue;
   logic          timer_en;
   logic          grant;
   data_t         rdata_q;

   assign issue    = (state_q == IDLE) && enable_i && req_i;
   assign timer_en = (state_q == WAIT) && req_i;
   assign grant    = (state_q == GRANT);

   cycle_counter #(.WIDTH(3)) wait_timer_i (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .en_i       (timer_en),
      .clr_i      (issue),
      .count_o    (hold_cnt)
   );

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (issue) state_d = WAIT;
         WAIT:    if (req_i && (hold_cnt == HOLD_LAST)) state_d = GRANT;
         GRANT:   state_d = IDLE;
         default: state_d = IDLE;
      endcase
      if (!enable_i) state_d = IDLE;  // port disabled, sequencer parked
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state_q  <= IDLE;
         bank.req <= 1'b0;
         rdata_q  <= '0;
      end else begin
         state_q  <= state_d;
         bank.req <= issue;  // exactly one bank access per request
         if ((state_q == WAIT) && bank.rvalid) rdata_q <= bank.rdata;
      end
   end

   // access payload captured with the strobe
   always_ff @(posedge asic_clk_i) begin
      if (issue) begin
         bank.we    <= we_i;
         bank.addr  <= addr_i;
         bank.wdata <= wdata_i;
         bank.be    <= be_i;
      end
   end

   // disabled port answers immediately with no data
   assign gnt_o    = enable_i ? grant   : req_i;
   assign rvalid_o = enable_i ? grant   : 1'b1;
   assign rdata_o  = enable_i ? rdata_q : '0;

endmodule

`default_nettype wire

// File: cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "efpga_cfg.svh"

module cycle_counter #(
   parameter int unsigned WIDTH = `EFPGA_PERF_W
) (
   input  logic             asic_clk_i,
   input  logic             rst_n,
   input  logic             en_i,
   input  logic             clr_i,
   output logic [WIDTH-1:0] count_o
);

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         count_o <= '0;
      end else if (clr_i) begin
         count_o <= '0;  // clear beats enable
      end else if (en_i) begin
         count_o <= count_o + 1'b1;  // wraps silently
      end
   end

endmodule

`default_nettype wire

// File: reg_access_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if
   import efpga_bus_pkg::*;
();

   logic  req;     // single cycle access strobe
   logic  we;      // 1 = write
   addr_t addr;
   data_t wdata;
   be_t   be;
   data_t rdata;   // word before any write
   logic  rvalid;  // one cycle after req

   modport requester (
      output req, we, addr, wdata, be,
      input  rdata, rvalid
   );

   modport responder (
      input  req, we, addr, wdata, be,
      output rdata, rvalid
   );

endinterface

`default_nettype wire

// File: efpga_ctrl_pkg.sv
`default_nettype none

`include "efpga_cfg.svh"

package efpga_ctrl_pkg;

   // control word shares the data bus width
   typedef logic [`EFPGA_DATA_W-1:0]   control_word_t;

   typedef logic [`EFPGA_N_EVENTS-1:0] event_vec_t;

   typedef logic [`EFPGA_PERF_W-1:0]   perf_count_t;

   // register port access sequencing
   typedef enum logic [1:0] {
      IDLE  = 2'd0,  // waiting for a host request
      WAIT  = 2'd1,  // access issued, holding off grant
      GRANT = 2'd2   // one cycle grant and read-valid
   } access_state_t;

endpackage

`default_nettype wire

// File: efpga_bus_pkg.sv
`default_nettype none

`include "efpga_cfg.svh"

package efpga_bus_pkg;

   localparam int unsigned BE_W    = `EFPGA_DATA_W / 8;
   localparam int unsigned IDX_W   = $clog2(`EFPGA_REG_WORDS);
   localparam int unsigned IDX_LSB = 2;  // word aligned, byte bits skipped

   typedef logic [`EFPGA_ADDR_W-1:0] addr_t;
   typedef logic [`EFPGA_DATA_W-1:0] data_t;
   typedef logic [BE_W-1:0]          be_t;
   typedef logic [IDX_W-1:0]         reg_idx_t;

   // upper address bits are don't care for the bank
   function automatic reg_idx_t addr_to_idx(addr_t addr);
      return addr[IDX_LSB +: IDX_W];
   endfunction

endpackage

`default_nettype wire

// File: efpga_cfg.svh
`ifndef EFPGA_CFG_SVH
`define EFPGA_CFG_SVH

// register port geometry
`define EFPGA_ADDR_W     20  // host register address
`define EFPGA_DATA_W     32  // data and control word width
`define EFPGA_REG_WORDS  16  // words in the stand-in fabric bank

// event and counter sizing
`define EFPGA_N_EVENTS   16  // fabric event lines
`define EFPGA_PERF_W     32  // performance counter width

// request must be sampled high this many edges before grant
`define EFPGA_GNT_CYCLES 4

`endif
